// File: Bender.yml
package:
  name: nocArbiter

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/nocArbiterPkg.sv
      - source/portHoldTimer.sv
      - source/switchAllocator.sv
      - source/outputStage.sv
      - source/routerOutputPort.sv

  - target: simulation
    include_dirs:
      - source
    files:
      - verification/clockGen.sv
      - verification/switchAllocator_assertions.sv
      - verification/routerOutputPortTb.sv

// File: nocArbiter.f
+incdir+source
source/nocArbiterPkg.sv
source/portHoldTimer.sv
source/switchAllocator.sv
source/outputStage.sv
source/routerOutputPort.sv
verification/clockGen.sv
verification/switchAllocator_assertions.sv
verification/routerOutputPortTb.sv

// File: source/nocArbiterPkg.sv
`default_nettype none

`include "nocArbiter_defines.svh"

package nocArbiterPkg;

  typedef struct packed {
    logic [`FLIT_WIDTH-`LENGTH_WIDTH-`FLIT_ID_WIDTH-1:0] spare;
    logic [`LENGTH_WIDTH-1:0]                          length;   // Hold limit in cycles
    logic [`FLIT_ID_WIDTH-1:0]                         flitId;
  } flitHeader_s;

  typedef struct packed {
    logic [`PAYLOAD_WIDTH-1:0] payload;
    logic [`FLIT_ID_WIDTH-1:0] flitId;
  } flitBody_s;

  // Same 16-bit word, decoded by flitId
  typedef union packed {
    flitHeader_s header;
    flitBody_s   body;
  } flitWord_u;

  typedef enum logic [5:0] {
    ALLOC_IDLE  = 6'b000001,
    ALLOC_LOCAL = 6'b000010,
    ALLOC_NORTH = 6'b000100,
    ALLOC_EAST  = 6'b001000,
    ALLOC_WEST  = 6'b010000,
    ALLOC_SOUTH = 6'b100000
  } allocState_e;

endpackage

`default_nettype wire

// File: source/nocArbiter_defines.svh
`ifndef NOC_ARBITER_DEFINES_SVH
`define NOC_ARBITER_DEFINES_SVH

// Flit word layout
`define FLIT_WIDTH     16
`define LENGTH_WIDTH   12
`define PAYLOAD_WIDTH  13
`define FLIT_ID_WIDTH  3

// Flit identifiers, one-hot
`define FLIT_ID_HEADER 3'b001
`define FLIT_ID_BODY   3'b010
`define FLIT_ID_TAIL   3'b100

// Local, North, East, West, South
`define NUM_PORTS      5

`endif

// File: source/outputStage.sv
`timescale 1ns/1ps
`default_nettype none

`include "nocArbiter_defines.svh"

module outputStage (
  input  logic                       clk,
  input  logic                       rst,
  input  nocArbiterPkg::allocState_e grant,
  input  logic                       localReq,
  input  logic                       northReq,
  input  logic                       eastReq,
  input  logic                       westReq,
  input  logic                       southReq,
  input  nocArbiterPkg::flitWord_u   localFlit,
  input  nocArbiterPkg::flitWord_u   northFlit,
  input  nocArbiterPkg::flitWord_u   eastFlit,
  input  nocArbiterPkg::flitWord_u   westFlit,
  input  nocArbiterPkg::flitWord_u   southFlit,
  output nocArbiterPkg::flitWord_u   flitOut,
  output logic                       flitValid
);

  import nocArbiterPkg::*;

  logic [`NUM_PORTS-1:0] reqVec;
  logic                  selReq;
  flitWord_u             selFlit;

  assign reqVec = {southReq, westReq, eastReq, northReq, localReq};
  assign selReq = |(grant[`NUM_PORTS:1] & reqVec);   // Zero while idle

  always_comb
  begin
    case (grant)
      ALLOC_LOCAL: selFlit = localFlit;
      ALLOC_NORTH: selFlit = northFlit;
      ALLOC_EAST:  selFlit = eastFlit;
      ALLOC_WEST:  selFlit = westFlit;
      ALLOC_SOUTH: selFlit = southFlit;
      default:     selFlit = '0;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      flitOut   <= '0;
      flitValid <= 1'b0;
    end
    else
    begin
      flitOut   <= selFlit;
      flitValid <= selReq;
    end
  end

endmodule

`default_nettype wire

// File: source/portHoldTimer.sv
`timescale 1ns/1ps
`default_nettype none

`include "nocArbiter_defines.svh"

module portHoldTimer (
  input  logic                     clk,
  input  logic                     rst,
  input  nocArbiterPkg::flitWord_u flit,
  input  logic                     run,
  output logic                     timesUp
);

  logic [`LENGTH_WIDTH-1:0] holdLimit;
  logic [`LENGTH_WIDTH-1:0] holdCount;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      holdLimit <= '0;
      holdCount <= '0;
    end
    else
    begin
      if (flit.header.flitId == `FLIT_ID_HEADER)   // Any header, granted or not
      begin
        holdLimit <= flit.header.length;
      end
      if (run)
      begin
        holdCount <= holdCount + 1'b1;
      end
      else
      begin
        holdCount <= '0;
      end
    end
  end

  // Grant lasts limit + 1 cycles
  assign timesUp = (holdCount == holdLimit);

endmodule

`default_nettype wire

// File: source/routerOutputPort.sv
`timescale 1ns/1ps
`default_nettype none

module routerOutputPort (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       localReq,
  input  logic                       northReq,
  input  logic                       eastReq,
  input  logic                       westReq,
  input  logic                       southReq,
  input  nocArbiterPkg::flitWord_u   localFlit,
  input  nocArbiterPkg::flitWord_u   northFlit,
  input  nocArbiterPkg::flitWord_u   eastFlit,
  input  nocArbiterPkg::flitWord_u   westFlit,
  input  nocArbiterPkg::flitWord_u   southFlit,
  output nocArbiterPkg::allocState_e grant,
  output nocArbiterPkg::flitWord_u   flitOut,
  output logic                       flitValid
);

  // Grant one cycle after the request edge
  switchAllocator allocator (
    .clk       (clk),
    .rst       (rst),
    .localReq  (localReq),
    .northReq  (northReq),
    .eastReq   (eastReq),
    .westReq   (westReq),
    .southReq  (southReq),
    .localFlit (localFlit),
    .northFlit (northFlit),
    .eastFlit  (eastFlit),
    .westFlit  (westFlit),
    .southFlit (southFlit),
    .grant     (grant)
  );

  // Flit and valid one cycle after grant
  outputStage outStage (
    .clk       (clk),
    .rst       (rst),
    .grant     (grant),
    .localReq  (localReq),
    .northReq  (northReq),
    .eastReq   (eastReq),
    .westReq   (westReq),
    .southReq  (southReq),
    .localFlit (localFlit),
    .northFlit (northFlit),
    .eastFlit  (eastFlit),
    .westFlit  (westFlit),
    .southFlit (southFlit),
    .flitOut   (flitOut),
    .flitValid (flitValid)
  );

endmodule

`default_nettype wire

// File: source/switchAllocator.sv
`timescale 1ns/1ps
`default_nettype none

`include "nocArbiter_defines.svh"

module switchAllocator (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       localReq,
  input  logic                       northReq,
  input  logic                       eastReq,
  input  logic                       westReq,
  input  logic                       southReq,
  input  nocArbiterPkg::flitWord_u   localFlit,
  input  nocArbiterPkg::flitWord_u   northFlit,
  input  nocArbiterPkg::flitWord_u   eastFlit,
  input  nocArbiterPkg::flitWord_u   westFlit,
  input  nocArbiterPkg::flitWord_u   southFlit,
  output nocArbiterPkg::allocState_e grant
);

  import nocArbiterPkg::*;

  allocState_e           state;
  allocState_e           nextState;
  logic [`NUM_PORTS-1:0] reqVec;      // Bit 0 is Local
  logic [`NUM_PORTS-1:0] timesUpVec;
  logic [`NUM_PORTS-1:0] holdVec;
  logic [`NUM_PORTS-1:0] runVec;

  // First requesting port among numPorts ports, starting at firstPort
  function automatic allocState_e rotateSearch(
    input logic [`NUM_PORTS-1:0] req,
    input int unsigned           firstPort,
    input int unsigned           numPorts
  );
    allocState_e pick;
    int unsigned idx;
    pick = ALLOC_IDLE;
    // Walk backwards so the nearest port is written last
    for (int i = `NUM_PORTS - 1; i >= 0; i--)
    begin
      idx = (firstPort + i) % `NUM_PORTS;
      if ((i < numPorts) && req[idx])
      begin
        pick = allocState_e'(6'b000010 << idx);
      end
    end
    return pick;
  endfunction

  assign reqVec  = {southReq, westReq, eastReq, northReq, localReq};
  assign holdVec = reqVec & ~timesUpVec;
  assign runVec  = state[`NUM_PORTS:1] & holdVec;   // Only the holder keeps counting

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state <= ALLOC_IDLE;
    end
    else
    begin
      state <= nextState;
    end
  end

  always_comb
  begin
    case (state)
      ALLOC_IDLE:  nextState = rotateSearch(reqVec, 0, `NUM_PORTS);
      ALLOC_LOCAL: nextState = holdVec[0] ? ALLOC_LOCAL : rotateSearch(reqVec, 1, 4);
      ALLOC_NORTH: nextState = holdVec[1] ? ALLOC_NORTH : rotateSearch(reqVec, 2, 4);
      ALLOC_EAST:  nextState = holdVec[2] ? ALLOC_EAST : rotateSearch(reqVec, 3, 4);
      ALLOC_WEST:  nextState = holdVec[3] ? ALLOC_WEST : rotateSearch(reqVec, 4, 4);
      ALLOC_SOUTH: nextState = holdVec[4] ? ALLOC_SOUTH : rotateSearch(reqVec, 0, 4);
      default:     nextState = ALLOC_IDLE;   // Recover from a broken one-hot code
    endcase
  end

  assign grant = state;

  portHoldTimer localTimer (
    .clk     (clk),
    .rst     (rst),
    .flit    (localFlit),
    .run     (runVec[0]),
    .timesUp (timesUpVec[0])
  );

  portHoldTimer northTimer (
    .clk     (clk),
    .rst     (rst),
    .flit    (northFlit),
    .run     (runVec[1]),
    .timesUp (timesUpVec[1])
  );

  portHoldTimer eastTimer (
    .clk     (clk),
    .rst     (rst),
    .flit    (eastFlit),
    .run     (runVec[2]),
    .timesUp (timesUpVec[2])
  );

  portHoldTimer westTimer (
    .clk     (clk),
    .rst     (rst),
    .flit    (westFlit),
    .run     (runVec[3]),
    .timesUp (timesUpVec[3])
  );

  portHoldTimer southTimer (
    .clk     (clk),
    .rst     (rst),
    .flit    (southFlit),
    .run     (runVec[4]),
    .timesUp (timesUpVec[4])
  );

endmodule

`default_nettype wire

// File: verification/clockGen.sv
`timescale 1ns/1ps
`default_nettype none

module clockGen (
  output logic clk,
  output logic rst
);

  localparam int HALF_PERIOD  = 50;   // 100 ns period
  localparam int RESET_CYCLES = 8;

  initial
  begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  initial
  begin
    rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;   // Released on a rising edge
  end

endmodule

`default_nettype wire

// File: verification/routerOutputPortTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "nocArbiter_defines.svh"

module routerOutputPortTb;

  import nocArbiterPkg::*;

  // Reset plus the six tests, in cycles
  localparam int TEST_CYCLES    = 10 + 6 + 12 + 12 + 16 + 26 + 10;
  localparam int TIMEOUT_CYCLES = TEST_CYCLES * 3 / 2;

  logic                     clk;
  logic                     rst;
  logic [`NUM_PORTS-1:0]    reqVec;   // Bit 0 is Local
  flitWord_u                flitArr [`NUM_PORTS];
  allocState_e              grant;
  flitWord_u                flitOut;
  logic                     flitValid;
  int                       mismatchCount = 0;
  int                       errorCount    = 0;
  int                       cycleCount;
  logic [15:0]              lfsrState     = 16'd7476;
  int                       mHolder;   // Model holder, -1 when idle
  logic [`LENGTH_WIDTH-1:0] mLimit [`NUM_PORTS];
  logic [`LENGTH_WIDTH-1:0] mCount [`NUM_PORTS];
  flitWord_u                mFlit;
  logic                     mValid;

  clockGen clocks (.clk(clk), .rst(rst));

  routerOutputPort i_dut (
    .clk       (clk),
    .rst       (rst),
    .localReq  (reqVec[0]),
    .northReq  (reqVec[1]),
    .eastReq   (reqVec[2]),
    .westReq   (reqVec[3]),
    .southReq  (reqVec[4]),
    .localFlit (flitArr[0]),
    .northFlit (flitArr[1]),
    .eastFlit  (flitArr[2]),
    .westFlit  (flitArr[3]),
    .southFlit (flitArr[4]),
    .grant     (grant),
    .flitOut   (flitOut),
    .flitValid (flitValid)
  );

  // Taps 16, 14, 13, 11
  function automatic logic [15:0] lfsrNext(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function logic [`PAYLOAD_WIDTH-1:0] randomPayload();
    logic [`PAYLOAD_WIDTH-1:0] value;
    value = '0;
    for (int i = 0; i < `PAYLOAD_WIDTH; i++)
    begin
      lfsrState = lfsrNext(lfsrState);
      value     = {value[`PAYLOAD_WIDTH-2:0], lfsrState[0]};
    end
    return value;
  endfunction

  function automatic flitWord_u headerFlit(input logic [`LENGTH_WIDTH-1:0] len);
    flitWord_u w;
    w.header.spare  = 1'b0;
    w.header.length = len;
    w.header.flitId = `FLIT_ID_HEADER;
    return w;
  endfunction

  function automatic flitWord_u bodyFlit(input logic [`PAYLOAD_WIDTH-1:0] payload);
    flitWord_u w;
    w.body.payload = payload;
    w.body.flitId  = `FLIT_ID_BODY;
    return w;
  endfunction

  function automatic allocState_e stateOf(input int port);
    case (port)
      0:       return ALLOC_LOCAL;
      1:       return ALLOC_NORTH;
      2:       return ALLOC_EAST;
      3:       return ALLOC_WEST;
      4:       return ALLOC_SOUTH;
      default: return ALLOC_IDLE;
    endcase
  endfunction

  always @(posedge clk)
  begin : refModel
    int nextHolder;
    int port;
    nextHolder = -1;
    if (rst)
    begin
      mHolder <= -1;
      mValid  <= 1'b0;
      mFlit   <= '0;
      for (int i = 0; i < `NUM_PORTS; i++)
      begin
        mLimit[i] <= '0;
        mCount[i] <= '0;
      end
    end
    else
    begin
      if (mHolder < 0)
      begin
        for (int k = 0; k < `NUM_PORTS; k++)
          if (nextHolder < 0 && reqVec[k])
            nextHolder = k;
      end
      else if (reqVec[mHolder] && mCount[mHolder] != mLimit[mHolder])
        nextHolder = mHolder;
      else
      begin
        for (int k = 1; k < `NUM_PORTS; k++)
        begin
          port = (mHolder + k) % `NUM_PORTS;   // Rotate past the old holder
          if (nextHolder < 0 && reqVec[port])
            nextHolder = port;
        end
      end
      for (int i = 0; i < `NUM_PORTS; i++)
      begin
        if (flitArr[i].header.flitId == `FLIT_ID_HEADER)
          mLimit[i] <= flitArr[i].header.length;
        mCount[i] <= (nextHolder == i && mHolder == i) ? mCount[i] + 1'b1 : '0;
      end
      if (mHolder >= 0)
      begin
        mValid <= reqVec[mHolder];
        mFlit  <= flitArr[mHolder];
      end
      else
      begin
        mValid <= 1'b0;
        mFlit  <= '0;
      end
      mHolder <= nextHolder;
    end
  end

  always @(negedge clk)
  begin
    assert (grant == stateOf(mHolder))
    else
    begin
      mismatchCount++;
      $display("Mismatch at %0t: grant %b, model expects %b", $time, grant, stateOf(mHolder));
    end
    assert (flitValid == mValid)
    else
    begin
      mismatchCount++;
      $display("Mismatch at %0t: flitValid %b, model expects %b", $time, flitValid, mValid);
    end
    assert (flitOut == mFlit)
    else
    begin
      mismatchCount++;
      $display("Mismatch at %0t: flitOut %h, model expects %h", $time, flitOut, mFlit);
    end
  end

  task automatic expectGrant(input allocState_e exp, input string what);
    @(negedge clk);
    assert (grant == exp)
    else
    begin
      mismatchCount++;
      $display("Mismatch at %0t: %s, grant %b expected %b", $time, what, grant, exp);
    end
  endtask

  task automatic expectValid(input logic exp, input string what);
    @(negedge clk);
    assert (flitValid == exp)
    else
    begin
      mismatchCount++;
      $display("Mismatch at %0t: %s, flitValid %b expected %b", $time, what, flitValid, exp);
    end
  endtask

  task automatic waitForGrant(input allocState_e target, input int maxCycles);
    int n;
    n = 0;
    @(negedge clk);
    while (grant != target && n < maxCycles)
    begin
      @(negedge clk);
      n++;
    end
    assert (grant == target)
    else
    begin
      errorCount++;
      $display("Grant never reached %s within %0d cycles", target.name(), maxCycles);
    end
  endtask

  task automatic dropAllRequests();
    @(posedge clk);
    reqVec <= '0;
    waitForGrant(ALLOC_IDLE, 3);
  endtask

  task automatic fixedPriorityTest();
    @(posedge clk);
    reqVec <= '1;
    @(posedge clk);
    expectGrant(ALLOC_LOCAL, "first grant from idle must go to Local");
    dropAllRequests();
  endtask

  task automatic holdLimitTest();
    @(posedge clk);
    flitArr[1] <= headerFlit(12'd3);
    reqVec     <= 5'b00010;
    @(posedge clk);
    flitArr[1] <= bodyFlit(randomPayload());
    repeat (4) expectGrant(ALLOC_NORTH, "North should hold for limit + 1 cycles");
    expectGrant(ALLOC_IDLE, "North should release after its hold limit");
    expectGrant(ALLOC_NORTH, "North should be granted again from idle");
    dropAllRequests();
  endtask

  task automatic rotationTest();
    allocState_e order [6];
    order = '{ALLOC_LOCAL, ALLOC_NORTH, ALLOC_EAST, ALLOC_WEST, ALLOC_SOUTH, ALLOC_LOCAL};
    @(posedge clk);
    for (int i = 0; i < `NUM_PORTS; i++)
      flitArr[i] <= headerFlit(12'd0);
    @(posedge clk);
    for (int i = 0; i < `NUM_PORTS; i++)
      flitArr[i] <= bodyFlit(randomPayload());
    reqVec <= '1;
    @(posedge clk);
    for (int i = 0; i < 6; i++)
      expectGrant(order[i], "grant should rotate round-robin");
    dropAllRequests();
  endtask

  task automatic headerOnlyTest();
    @(posedge clk);
    flitArr[2] <= bodyFlit(13'h0FFF);   // Header view reads length 0xFFF
    reqVec     <= 5'b00100;
    waitForGrant(ALLOC_EAST, 3);
    expectGrant(ALLOC_IDLE, "a body flit must not change the East limit");
    dropAllRequests();
    @(posedge clk);
    flitArr[2] <= headerFlit(12'd2);
    @(posedge clk);
    flitArr[2] <= bodyFlit(randomPayload());
    reqVec     <= 5'b00100;
    @(posedge clk);
    repeat (3) expectGrant(ALLOC_EAST, "East should hold for the limit from its header");
    expectGrant(ALLOC_IDLE, "East should release after the new limit");
    dropAllRequests();
  endtask

  task automatic dataPathTest();
    for (int c = 0; c < 20; c++)
    begin
      @(posedge clk);
      for (int i = 0; i < `NUM_PORTS; i++)
        flitArr[i] <= bodyFlit(randomPayload());
      reqVec <= '1;
    end
    expectValid(1'b1, "flitValid should be high while the granted port requests");
    @(posedge clk);
    reqVec <= '0;
    expectValid(1'b1, "flitValid should stay high for the last requested cycle");
    expectValid(1'b0, "flitValid should drop one cycle after the request is withdrawn");
  endtask

  task automatic earlyReleaseTest();
    @(posedge clk);
    flitArr[1] <= headerFlit(12'd3);
    flitArr[2] <= headerFlit(12'd3);
    @(posedge clk);
    flitArr[1] <= bodyFlit(randomPayload());
    flitArr[2] <= bodyFlit(randomPayload());
    reqVec     <= 5'b00110;
    waitForGrant(ALLOC_NORTH, 3);
    @(posedge clk);
    reqVec[1] <= 1'b0;   // North leaves before its limit
    expectGrant(ALLOC_NORTH, "North should still hold below its limit");
    expectGrant(ALLOC_EAST, "grant should rotate to East after North releases");
    @(posedge clk);
    reqVec[2] <= 1'b0;
    expectGrant(ALLOC_EAST, "East should still hold below its limit");
    expectGrant(ALLOC_IDLE, "grant should go idle when no other port requests");
  endtask

  task automatic printCounts();
    $display("Summary: %0d mismatches, %0d other errors, %0d assertion failures",
             mismatchCount, errorCount, i_dut.allocator.allocatorChecks.failCount);
  endtask

  initial
  begin
    reqVec = '0;
    for (int i = 0; i < `NUM_PORTS; i++)
      flitArr[i] = '0;
    @(negedge rst);
    fixedPriorityTest();
    holdLimitTest();
    rotationTest();
    headerOnlyTest();
    dataPathTest();
    earlyReleaseTest();
    printCounts();
    if (mismatchCount == 0 && errorCount == 0 &&
        i_dut.allocator.allocatorChecks.failCount == 0)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  end

  initial
  begin
    for (cycleCount = 0; cycleCount < TIMEOUT_CYCLES; cycleCount++)
      @(posedge clk);
    errorCount++;
    $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
    printCounts();
    $display("Errors found");
    $finish;
  end

endmodule

`default_nettype wire

// File: verification/switchAllocator_assertions.sv
`timescale 1ns/1ps
`default_nettype none

`include "nocArbiter_defines.svh"

module allocatorAssertions (
  input  logic                       clk,
  input  logic                       rst,
  input  nocArbiterPkg::allocState_e grant,
  input  logic [`NUM_PORTS-1:0]      reqVec,
  input  logic [`NUM_PORTS-1:0]      timesUpVec
);

  import nocArbiterPkg::*;

  logic [`NUM_PORTS-1:0] grantPorts;
  int                    failCount = 0;   // Failed assertions so far

  assign grantPorts = grant[`NUM_PORTS:1];   // Bit 0 is Local

  grantOneHot: assert property (@(posedge clk) disable iff (rst)
    $onehot(grant))
    else
    begin
      failCount++;
      $error("Grant is not one-hot");
    end

  idleWithoutRequests: assert property (@(posedge clk) disable iff (rst)
    (reqVec == '0) |=> (grant == ALLOC_IDLE))
    else
    begin
      failCount++;
      $error("Grant did not go idle although no port requested");
    end

  // Holder must leave once its timer has expired
  holdWithinLimit: assert property (@(posedge clk) disable iff (rst)
    ((grantPorts & timesUpVec) != '0) |=> (grant != $past(grant)))
    else
    begin
      failCount++;
      $error("Grant was held past its hold limit");
    end

  grantOnlyToRequester: assert property (@(posedge clk) disable iff (rst)
    1'b1 |=> ((grant == ALLOC_IDLE) || ((grantPorts & $past(reqVec)) != '0)))
    else
    begin
      failCount++;
      $error("Grant moved to a port that was not requesting");
    end

endmodule

bind switchAllocator allocatorAssertions allocatorChecks (
  .clk        (clk),
  .rst        (rst),
  .grant      (grant),
  .reqVec     (reqVec),
  .timesUpVec (timesUpVec)
);

`default_nettype wire
